// File: hw/bank_readout.sv
//--------------------------------------------------------------------
// dma_start while a stream runs is ignored; dma_clear outside a stream
// is ignored as well
//--------------------------------------------------------------------
`timescale 1ns/100ps
module bank_readout (
  input  logic readout_clk,
  input  logic capture_reset,
  input  logic banking_mode,
  input  logic cmd_dma_start,
  input  logic cmd_dma_clear,
  input  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DEPTH_BITS-1:0] bank_depth,
  output logic rd_bank,
  output logic [sample_buffer_pkg::ADDR_BITS-1:0] rd_addr,
  input  logic [sample_buffer_pkg::DATA_WIDTH-1:0] rd_data,
  output logic out_valid,
  output logic [sample_buffer_pkg::DATA_WIDTH-1:0] out_data,
  output logic out_last,
  input  logic out_ready
);

  localparam int AB = sample_buffer_pkg::ADDR_BITS;

  logic                                     streaming;
  logic [sample_buffer_pkg::DEPTH_BITS-1:0] idx;
  logic [sample_buffer_pkg::DEPTH_BITS-1:0] idx_next;
  logic [sample_buffer_pkg::DEPTH_BITS-1:0] idx_b1;
  logic [sample_buffer_pkg::DEPTH_BITS-1:0] total;
  logic                                     rd_pending;
  logic                                     rd_last_q;
  logic                                     issue;
  logic                                     pop;
  logic [2:0]                               in_use;
  // two-entry skid buffer
  logic [sample_buffer_pkg::DATA_WIDTH-1:0] fifo_data [2];
  logic [1:0]                               fifo_last;
  logic                                     wr_ptr;
  logic                                     rd_ptr;
  logic [1:0]                               fifo_count;

  assign out_valid = (fifo_count != 2'd0);
  assign out_data  = fifo_data[rd_ptr];
  assign out_last  = fifo_last[rd_ptr];

  always_comb begin
    total    = banking_mode ? bank_depth[0] : bank_depth[0] + bank_depth[1];
    idx_next = idx + {{(sample_buffer_pkg::DEPTH_BITS-1){1'b0}}, 1'b1};
    idx_b1   = idx - bank_depth[0];
    // stream index to bank and address
    if (banking_mode) begin
      rd_bank = idx[AB];
      rd_addr = idx[AB-1:0];
    end else if (idx < bank_depth[0]) begin
      rd_bank = 1'b0;
      rd_addr = idx[AB-1:0];
    end else begin
      rd_bank = 1'b1;
      rd_addr = idx_b1[AB-1:0];
    end
    pop    = out_valid && out_ready;
    // entries held next cycle, counting the read in flight
    in_use = {1'b0, fifo_count} + {2'b00, rd_pending} - {2'b00, pop};
    issue  = streaming && (idx < total) && (in_use < 3'd2);
  end

  always_ff @(posedge readout_clk) begin
    if (capture_reset) begin
      streaming  <= 1'b0;
      idx        <= '0;
      rd_pending <= 1'b0;
      fifo_count <= 2'd0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
    end else if (cmd_dma_clear && streaming) begin
      // the read in flight is dropped with the buffer contents
      streaming  <= 1'b0;
      rd_pending <= 1'b0;
      fifo_count <= 2'd0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
    end else begin
      rd_pending <= issue;
      if (cmd_dma_start && !streaming && total != '0) begin
        streaming <= 1'b1;
        idx       <= '0;
      end else begin
        if (issue) begin
          idx <= idx_next;
        end
        if (pop && out_last) begin
          streaming <= 1'b0;
        end
      end
      if (rd_pending) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      fifo_count <= fifo_count + {1'b0, rd_pending} - {1'b0, pop};
    end
  end

  always_ff @(posedge readout_clk) begin
    rd_last_q <= (idx_next == total);
    if (rd_pending) begin
      fifo_data[wr_ptr] <= rd_data;
      fifo_last[wr_ptr] <= rd_last_q;
    end
  end

endmodule

// File: hw/buffer_regs.sv
//--------------------------------------------------------------------
// wishbone classic, one ack per request; command bits act only at the ack
// edge and are not stored, so reading REG_CMD returns zero
//--------------------------------------------------------------------
`timescale 1ns/100ps
module buffer_regs (
  input  logic        readout_clk,
  input  logic        capture_reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  input  logic [1:0]  capture_state,
  input  logic        capture_full,
  output logic        cmd_arm,
  output logic        cmd_sw_start,
  output logic        cmd_sw_stop,
  output logic        cmd_capture_clear,
  output logic        cmd_dma_clear,
  output logic        cmd_dma_start,
  output logic        banking_mode
);

  logic                         req;
  logic                         wr_cmd;
  sample_buffer_pkg::ctl_word_u wr_word;

  // new request only while no ack is pending
  assign req     = wb_cyc && wb_stb && !wb_ack;
  assign wr_word = wb_dat_w;
  assign wr_cmd  = req && wb_we && (wb_adr == sample_buffer_pkg::REG_CMD);

  // pulses are high in the cycle before the ack edge, so consumers act at it
  assign cmd_arm           = wr_cmd && wr_word.cmd.arm;
  assign cmd_sw_start      = wr_cmd && wr_word.cmd.sw_start;
  assign cmd_sw_stop       = wr_cmd && wr_word.cmd.sw_stop;
  assign cmd_capture_clear = wr_cmd && wr_word.cmd.capture_clear;
  assign cmd_dma_clear     = wr_cmd && wr_word.cmd.dma_clear;
  assign cmd_dma_start     = wr_cmd && wr_word.cmd.dma_start;

  always_ff @(posedge readout_clk) begin
    if (capture_reset) begin
      wb_ack       <= 1'b0;
      banking_mode <= 1'b0;
    end else begin
      wb_ack <= req;
      if (req && wb_we && (wb_adr == sample_buffer_pkg::REG_CFG)) begin
        banking_mode <= wr_word.cfg.banking_mode;
      end
    end
  end

  // read data lines up with the ack
  always_ff @(posedge readout_clk) begin
    if (req) begin
      case (wb_adr)
        sample_buffer_pkg::REG_STATUS: wb_dat_r <= {28'd0, banking_mode, capture_full, capture_state};
        sample_buffer_pkg::REG_CFG:    wb_dat_r <= {31'd0, banking_mode};
        default:                       wb_dat_r <= 32'd0;
      endcase
    end
  end

endmodule

// File: hw/capture_control.sv
//--------------------------------------------------------------------
// after a stop or full the FSM waits in done until capture_clear, so every
// new capture starts from empty banks
//--------------------------------------------------------------------
`timescale 1ns/100ps
module capture_control (
  input  logic       readout_clk,
  input  logic       capture_reset,
  input  logic       cmd_arm,
  input  logic       cmd_sw_start,
  input  logic       cmd_sw_stop,
  input  logic       cmd_capture_clear,
  input  logic       hw_start,
  input  logic       hw_stop,
  input  logic [sample_buffer_pkg::CHANNELS-1:0] sample_valid,
  input  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DATA_WIDTH-1:0] sample_data,
  input  logic       banks_full,
  output logic [1:0] capture_state,
  output logic [sample_buffer_pkg::CHANNELS-1:0] save_valid,
  output logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DATA_WIDTH-1:0] save_data,
  output logic       capture_end,
  output logic       capture_clear
);

  logic saving;
  logic start_now;
  logic stop_now;

  assign saving = (capture_state == sample_buffer_pkg::ST_SAVING);

  always_comb begin
    // sw_start is taken in idle or armed, hw_start only once armed
    start_now = (cmd_sw_start && (capture_state == sample_buffer_pkg::ST_IDLE ||
                                  capture_state == sample_buffer_pkg::ST_ARMED)) ||
                (hw_start && capture_state == sample_buffer_pkg::ST_ARMED);
    // stops outside saving fall through with no effect
    stop_now  = saving && (cmd_sw_stop || hw_stop || banks_full);
  end

  always_ff @(posedge readout_clk) begin
    if (capture_reset) begin
      capture_state <= sample_buffer_pkg::ST_IDLE;
      save_valid    <= '0;
      capture_end   <= 1'b0;
      capture_clear <= 1'b0;
    end else begin
      capture_clear <= cmd_capture_clear;
      capture_end   <= stop_now && !cmd_capture_clear;

      // the sample at a stop edge is already dropped
      if (saving && !stop_now && !cmd_capture_clear) begin
        save_valid <= sample_valid;
      end else begin
        save_valid <= '0;
      end

      if (cmd_capture_clear) begin
        capture_state <= sample_buffer_pkg::ST_IDLE;
      end else if (stop_now) begin
        capture_state <= sample_buffer_pkg::ST_DONE;
      end else if (start_now) begin
        capture_state <= sample_buffer_pkg::ST_SAVING;
      end else if (cmd_arm && capture_state == sample_buffer_pkg::ST_IDLE) begin
        capture_state <= sample_buffer_pkg::ST_ARMED;
      end
    end
  end

  // data rides along, only the valids are gated
  always_ff @(posedge readout_clk) begin
    save_data <= sample_data;
  end

endmodule

// File: hw/sample_banks.sv
//--------------------------------------------------------------------
// writes past a channel's capacity are dropped; banking_mode must hold
// steady from the start of a capture until its readout is finished
//--------------------------------------------------------------------
`timescale 1ns/100ps
module sample_banks (
  input  logic readout_clk,
  input  logic capture_reset,
  input  logic banking_mode,
  input  logic [sample_buffer_pkg::CHANNELS-1:0] save_valid,
  input  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DATA_WIDTH-1:0] save_data,
  input  logic capture_end,
  input  logic capture_clear,
  output logic banks_full,
  output logic capture_full,
  input  logic rd_bank,
  input  logic [sample_buffer_pkg::ADDR_BITS-1:0] rd_addr,
  output logic [sample_buffer_pkg::DATA_WIDTH-1:0] rd_data,
  output logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DEPTH_BITS-1:0] bank_depth,
  output logic depth_valid,
  input  logic depth_ready,
  output logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DEPTH_BITS-1:0] depth_data
);

  localparam int AB = sample_buffer_pkg::ADDR_BITS;

  logic [sample_buffer_pkg::DATA_WIDTH-1:0] mem [sample_buffer_pkg::CHANNELS]
                                                 [sample_buffer_pkg::BANK_DEPTH];
  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DEPTH_BITS-1:0] wr_count;
  logic [sample_buffer_pkg::CHANNELS-1:0]                                 cnt_inc;
  logic [sample_buffer_pkg::CHANNELS-1:0]                                 req_en;
  logic [sample_buffer_pkg::CHANNELS-1:0][AB-1:0]                         req_addr;
  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DATA_WIDTH-1:0] req_data;
  logic [sample_buffer_pkg::CHANNELS-1:0]                                 wr_en_q;
  logic [sample_buffer_pkg::CHANNELS-1:0][AB-1:0]                         wr_addr_q;
  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DATA_WIDTH-1:0] wr_data_q;
  logic                                                                   end_q;

  assign bank_depth = wr_count;

  // bit AB set means 16 written, bit AB+1 means 32
  assign banks_full = banking_mode ? wr_count[0][AB+1]
                                   : (wr_count[0][AB] && wr_count[1][AB]);

  // route each saved word to a bank slot
  always_comb begin
    req_en   = '0;
    req_addr = '0;
    req_data = save_data;
    cnt_inc  = '0;
    if (!banking_mode) begin
      for (int c = 0; c < sample_buffer_pkg::CHANNELS; c++) begin
        req_addr[c] = wr_count[c][AB-1:0];
        if (save_valid[c] && !wr_count[c][AB]) begin
          req_en[c]  = 1'b1;
          cnt_inc[c] = 1'b1;
        end
      end
    end else if (save_valid[0] && !wr_count[0][AB+1]) begin
      // channel 0 fills bank 0, then bank 1
      req_en[wr_count[0][AB]]   = 1'b1;
      req_addr[wr_count[0][AB]] = wr_count[0][AB-1:0];
      req_data[wr_count[0][AB]] = save_data[0];
      cnt_inc[0]                = 1'b1;
    end
  end

  always_ff @(posedge readout_clk) begin
    if (capture_reset || capture_clear) begin
      wr_count     <= '0;
      wr_en_q      <= '0;
      capture_full <= 1'b0;
      end_q        <= 1'b0;
      depth_valid  <= 1'b0;
    end else begin
      wr_en_q <= req_en;
      for (int c = 0; c < sample_buffer_pkg::CHANNELS; c++) begin
        wr_count[c] <= wr_count[c] + {{(sample_buffer_pkg::DEPTH_BITS-1){1'b0}}, cnt_inc[c]};
      end
      capture_full <= capture_full || banks_full;
      end_q        <= capture_end;
      if (end_q) begin
        depth_valid <= 1'b1;
      end else if (depth_ready) begin
        depth_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge readout_clk) begin
    wr_addr_q <= req_addr;
    wr_data_q <= req_data;
    for (int b = 0; b < sample_buffer_pkg::CHANNELS; b++) begin
      if (wr_en_q[b]) begin
        mem[b][wr_addr_q[b]] <= wr_data_q[b];
      end
    end
    rd_data <= mem[rd_bank][rd_addr];
    // counts are final one cycle after capture_end
    if (end_q) begin
      depth_data <= wr_count;
    end
  end

endmodule

// File: hw/sample_buffer.sv
//--------------------------------------------------------------------
// one clock for capture and readout; two channels, two banks of 16 words
//--------------------------------------------------------------------
`timescale 1ns/100ps
module sample_buffer (
  input  logic        readout_clk,
  input  logic        capture_reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  input  logic        hw_start,
  input  logic        hw_stop,
  input  logic [sample_buffer_pkg::CHANNELS-1:0] sample_valid,
  input  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DATA_WIDTH-1:0] sample_data,
  output logic        capture_full,
  output logic        depth_valid,
  input  logic        depth_ready,
  output logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DEPTH_BITS-1:0] depth_data,
  output logic        out_valid,
  input  logic        out_ready,
  output logic [sample_buffer_pkg::DATA_WIDTH-1:0] out_data,
  output logic        out_last
);

  logic [1:0] capture_state;
  logic       cmd_arm;
  logic       cmd_sw_start;
  logic       cmd_sw_stop;
  logic       cmd_capture_clear;
  logic       cmd_dma_clear;
  logic       cmd_dma_start;
  logic       banking_mode;
  logic       capture_end;
  logic       capture_clear;
  logic       banks_full;
  logic       rd_bank;
  logic [sample_buffer_pkg::CHANNELS-1:0] save_valid;
  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DATA_WIDTH-1:0] save_data;
  logic [sample_buffer_pkg::ADDR_BITS-1:0]  rd_addr;
  logic [sample_buffer_pkg::DATA_WIDTH-1:0] rd_data;
  logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DEPTH_BITS-1:0] bank_depth;

  buffer_regs buffer_regs_i (.readout_clk, .capture_reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
    .wb_dat_w, .wb_dat_r, .wb_ack, .capture_state, .capture_full, .cmd_arm, .cmd_sw_start,
    .cmd_sw_stop, .cmd_capture_clear, .cmd_dma_clear, .cmd_dma_start, .banking_mode);

  // stage one
  capture_control capture_control_i (.readout_clk, .capture_reset, .cmd_arm, .cmd_sw_start,
    .cmd_sw_stop, .cmd_capture_clear, .hw_start, .hw_stop, .sample_valid, .sample_data,
    .banks_full, .capture_state, .save_valid, .save_data, .capture_end, .capture_clear);

  // stage two
  sample_banks sample_banks_i (.readout_clk, .capture_reset, .banking_mode, .save_valid,
    .save_data, .capture_end, .capture_clear, .banks_full, .capture_full, .rd_bank, .rd_addr,
    .rd_data, .bank_depth, .depth_valid, .depth_ready, .depth_data);

  // stage three
  bank_readout bank_readout_i (.readout_clk, .capture_reset, .banking_mode, .cmd_dma_start,
    .cmd_dma_clear, .bank_depth, .rd_bank, .rd_addr, .rd_data, .out_valid, .out_data,
    .out_last, .out_ready);

endmodule

// File: hw/sample_buffer_pkg.sv
//--------------------------------------------------------------------
// BANK_DEPTH must equal 2**ADDR_BITS, and DEPTH_BITS must hold twice it
//--------------------------------------------------------------------
package sample_buffer_pkg;

  localparam int CHANNELS   = 2;
  localparam int DATA_WIDTH = 16;
  localparam int BANK_DEPTH = 16;
  localparam int ADDR_BITS  = 4;
  // one extra bit so a chained channel can count to 32
  localparam int DEPTH_BITS = 6;

  // wishbone word addresses
  localparam logic [1:0] REG_CMD    = 2'd0;
  localparam logic [1:0] REG_CFG    = 2'd1;
  localparam logic [1:0] REG_STATUS = 2'd2;

  // capture state codes, also seen in the status word
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ARMED  = 2'd1;
  localparam logic [1:0] ST_SAVING = 2'd2;
  localparam logic [1:0] ST_DONE   = 2'd3;

  // write data word, read as cmd at REG_CMD and as cfg at REG_CFG
  typedef union packed {
    struct packed {
      logic [25:0] rsvd;
      logic        dma_start;
      logic        dma_clear;
      logic        capture_clear;
      logic        sw_stop;
      logic        sw_start;
      logic        arm;
    } cmd;
    struct packed {
      logic [30:0] rsvd;
      // 0 one bank per channel, 1 both banks behind channel 0
      logic        banking_mode;
    } cfg;
  } ctl_word_u;

endpackage

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sample_buffer_tb -f verilog.f \
  && ./obj_dir/Vsample_buffer_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log 2>/dev/null && exit 0 || exit 1

// File: test/sample_buffer_chk.sv
//--------------------------------------------------------------------
// assumes the master holds wb_cyc and wb_stb over the edge it samples ack
//--------------------------------------------------------------------
`timescale 1ns/100ps
module sample_buffer_chk (
  input logic readout_clk,
  input logic capture_reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic cmd_dma_clear,
  input logic out_valid,
  input logic out_ready,
  input logic out_last,
  input logic [sample_buffer_pkg::DATA_WIDTH-1:0] out_data,
  input logic depth_valid,
  input logic depth_ready,
  input logic [sample_buffer_pkg::CHANNELS-1:0][sample_buffer_pkg::DEPTH_BITS-1:0] depth_data
);

  ack_in_cycle: assert property (@(posedge readout_clk) disable iff (capture_reset)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack outside an active wishbone cycle");

  // dma_clear is the one legal way to drop a word that is waiting
  out_held: assert property (@(posedge readout_clk) disable iff (capture_reset)
    (out_valid && !out_ready && !cmd_dma_clear) |=>
      (out_valid && $stable(out_data) && $stable(out_last)))
    else $error("sample stream changed while stalled");

  depth_held: assert property (@(posedge readout_clk) disable iff (capture_reset)
    (depth_valid && !depth_ready) |=> (depth_valid && $stable(depth_data)))
    else $error("depth report changed while stalled");

  clear_drops_valid: assert property (@(posedge readout_clk) disable iff (capture_reset)
    cmd_dma_clear |=> !out_valid)
    else $error("out_valid still high after dma_clear");

endmodule

// File: test/sample_buffer_tb_tests.svh
//--------------------------------------------------------------------
// test sequence inside the testbench module; every task starts and ends
// 10 ns after a rising edge
//--------------------------------------------------------------------
  task automatic hw_pulse(input logic is_start);
    if (is_start) hw_start = 1'b1;
    else hw_stop = 1'b1;
    tick(1);
    hw_start = 1'b0;
    hw_stop  = 1'b0;
  endtask

  task automatic set_mode(input logic m);
    sample_buffer_pkg::ctl_word_u w;
    w                  = '0;
    w.cfg.banking_mode = m;
    wb_write(sample_buffer_pkg::REG_CFG, w);
    mode = m;
  endtask

  task automatic start_stream();
    build_stream();
    wb_write(sample_buffer_pkg::REG_CMD, cmd_word("dma_start"));
  endtask

  task automatic wait_until_left(input int left);
    int n;
    n = 0;
    while (exp_stream.size() > left && n < 400) begin
      tick(1);
      n++;
    end
    if (exp_stream.size() > left) begin
      other_errors++;
      $display("t=%0t sample stream stalled with %0d words owed", $time, exp_stream.size());
    end
    // a few more cycles to catch stray words
    tick(8);
  endtask

  task automatic wait_report(input int count);
    int n;
    n = 0;
    while (depth_reports < count && n < 100) begin
      tick(1);
      n++;
    end
    check_count("depth reports", depth_reports, count);
  endtask

  task automatic wait_full();
    int n;
    n = 0;
    while (!capture_full && n < 400) begin
      tick(1);
      n++;
    end
    if (!capture_full) begin
      other_errors++;
      $display("t=%0t capture_full never rose", $time);
    end
    window = 1'b0;
  endtask

  task automatic clear_capture();
    logic [31:0] status;
    wb_write(sample_buffer_pkg::REG_CMD, cmd_word("capture_clear"));
    ch0_q.delete();
    ch1_q.delete();
    wb_read(sample_buffer_pkg::REG_STATUS, status);
    check_state("capture_state", status[1:0], sample_buffer_pkg::ST_IDLE);
    check_flag("capture_full", status[2], 1'b0);
    check_flag("banking_mode", status[3], mode);
  endtask

  task automatic run_tests();
    logic [31:0] status;
    // start and stop without arming do nothing
    hw_pulse(1'b1);
    hw_pulse(1'b0);
    wb_read(sample_buffer_pkg::REG_STATUS, status);
    check_state("capture_state", status[1:0], sample_buffer_pkg::ST_IDLE);
    start_stream();
    tick(20);
    check_count("depth reports", depth_reports, 0);

    // mode 0 until both banks are full
    wb_write(sample_buffer_pkg::REG_CMD, cmd_word("arm"));
    hw_pulse(1'b1);
    window = 1'b1;
    wait_full();
    wait_report(1);
    start_stream();
    wait_until_left(0);
    clear_capture();

    // mode 1, then a stream cut in half by dma_clear and restarted
    set_mode(1'b1);
    wb_write(sample_buffer_pkg::REG_CMD, cmd_word("arm"));
    hw_pulse(1'b1);
    window = 1'b1;
    wait_full();
    wait_report(2);
    start_stream();
    wait_until_left(BANK_DEPTH);
    wb_write(sample_buffer_pkg::REG_CMD, cmd_word("dma_clear"));
    start_stream();
    wait_until_left(0);
    clear_capture();
    set_mode(1'b0);

    // software start and stop around a short burst
    wb_write(sample_buffer_pkg::REG_CMD, cmd_word("sw_start"));
    tick(12);
    wb_write(sample_buffer_pkg::REG_CMD, cmd_word("sw_stop"));
    wait_report(3);
    wb_read(sample_buffer_pkg::REG_STATUS, status);
    check_state("capture_state", status[1:0], sample_buffer_pkg::ST_DONE);
    start_stream();
    wait_until_left(0);
    clear_capture();
    tick(20);
    check_count("depth reports", depth_reports, 3);
  endtask

// File: test/sample_buffer_tb.sv
//--------------------------------------------------------------------
// inputs change 10 ns after the rising edge, results are sampled on the
// falling edge; needs a simulator with timing support
//--------------------------------------------------------------------
`timescale 1ns/100ps
module sample_buffer_tb;

  localparam int CHANNELS   = 2;
  localparam int DATA_WIDTH = 16;
  localparam int BANK_DEPTH = 16;
  localparam int DB         = sample_buffer_pkg::DEPTH_BITS;
  // longest sequence is near 3000 cycles with slow handshakes
  localparam int MAX_CYCLES = 6000;

  logic                                readout_clk;
  logic                                capture_reset;
  logic                                wb_cyc;
  logic                                wb_stb;
  logic                                wb_we;
  logic [1:0]                          wb_adr;
  logic [31:0]                         wb_dat_w;
  logic [31:0]                         wb_dat_r;
  logic                                wb_ack;
  logic                                hw_start;
  logic                                hw_stop;
  logic [CHANNELS-1:0]                 sample_valid;
  logic [CHANNELS-1:0][DATA_WIDTH-1:0] sample_data;
  logic                                capture_full;
  logic                                depth_valid;
  logic                                depth_ready;
  logic [CHANNELS-1:0][DB-1:0]         depth_data;
  logic                                out_valid;
  logic                                out_ready;
  logic [DATA_WIDTH-1:0]               out_data;
  logic                                out_last;

  logic [31:0]           rng;
  logic                  window;
  logic                  mode;
  int                    data_errors;
  int                    other_errors;
  int                    depth_reports;
  int                    cycles;
  logic [DATA_WIDTH-1:0] ch0_q[$];
  logic [DATA_WIDTH-1:0] ch1_q[$];
  logic [DATA_WIDTH-1:0] exp_stream[$];

  sample_buffer sample_buffer_i (.*);

  bind sample_buffer sample_buffer_chk sample_buffer_chk_i (.readout_clk, .capture_reset,
    .wb_cyc, .wb_stb, .wb_ack, .cmd_dma_clear, .out_valid, .out_ready, .out_last, .out_data,
    .depth_valid, .depth_ready, .depth_data);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // saved words of one channel, capped by what its banks can hold
  function automatic logic [DB-1:0] exp_depth(input int ch);
    int cap;
    int n;
    cap = mode ? ((ch == 0) ? 2 * BANK_DEPTH : 0) : BANK_DEPTH;
    n   = (ch == 0) ? ch0_q.size() : ch1_q.size();
    return DB'((n < cap) ? n : cap);
  endfunction

  // channel 0 words first, then channel 1, each in arrival order
  function automatic void build_stream();
    exp_stream.delete();
    for (int i = 0; i < exp_depth(0); i++) begin
      exp_stream.push_back(ch0_q[i]);
    end
    for (int i = 0; i < exp_depth(1); i++) begin
      exp_stream.push_back(ch1_q[i]);
    end
  endfunction

  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_depth(input string name, input logic [DB-1:0] got,
                             input logic [DB-1:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      data_errors++;
      $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      data_errors++;
      $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge readout_clk);
      #10;
    end
  endtask

  // the ack edge is the first edge after the request is driven
  task automatic wb_access(input logic [1:0] adr, input logic we, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    sample_buffer_pkg::ctl_word_u w;
    logic                         is_cmd;
    int                           waited;
    w      = wdata;
    is_cmd = we && (adr == sample_buffer_pkg::REG_CMD);
    waited = 0;
    // samples from the ack edge on are dropped
    if (is_cmd && (w.cmd.sw_stop || w.cmd.capture_clear)) begin
      window = 1'b0;
    end
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      tick(1);
      waited++;
    end while (!wb_ack && waited < 8);
    if (!wb_ack) begin
      other_errors++;
      $display("t=%0t wishbone slave gave no ack within 8 cycles", $time);
    end else if (is_cmd && w.cmd.sw_start) begin
      // first saved sample is the one at the edge after the ack
      window = 1'b1;
    end
    rdata = wb_dat_r;
    tick(1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    logic [31:0] rd_ignored;
    wb_access(adr, 1'b1, data, rd_ignored);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    wb_access(adr, 1'b0, 32'd0, data);
  endtask

  function automatic logic [31:0] cmd_word(input string name);
    sample_buffer_pkg::ctl_word_u w;
    w = '0;
    if (name == "arm") w.cmd.arm = 1'b1;
    else if (name == "sw_start") w.cmd.sw_start = 1'b1;
    else if (name == "sw_stop") w.cmd.sw_stop = 1'b1;
    else if (name == "capture_clear") w.cmd.capture_clear = 1'b1;
    else if (name == "dma_clear") w.cmd.dma_clear = 1'b1;
    else if (name == "dma_start") w.cmd.dma_start = 1'b1;
    return w;
  endfunction

  `include "sample_buffer_tb_tests.svh"

  initial begin
    readout_clk = 1'b0;
    forever #50 readout_clk = ~readout_clk;
  end

  // random samples and ready lines every cycle
  always @(posedge readout_clk) begin
    #10;
    rng = lcg_next(rng);
    sample_valid = rng[31:30];
    out_ready    = rng[29] | rng[28];
    depth_ready  = rng[27];
    rng = lcg_next(rng);
    sample_data[0] = rng[31:16];
    rng = lcg_next(rng);
    sample_data[1] = rng[31:16];
  end

  // falling edge shows what the next rising edge will take
  always @(negedge readout_clk) begin
    if (!capture_reset) begin
      if (window && sample_valid[0]) begin
        ch0_q.push_back(sample_data[0]);
      end
      if (window && sample_valid[1]) begin
        ch1_q.push_back(sample_data[1]);
      end
      if (depth_valid && depth_ready) begin
        depth_reports++;
        check_depth("depth_data[0]", depth_data[0], exp_depth(0));
        check_depth("depth_data[1]", depth_data[1], exp_depth(1));
      end
      if (out_valid && out_ready) begin
        if (exp_stream.size() == 0) begin
          other_errors++;
          $display("t=%0t sample stream sent a word that was not expected", $time);
        end else begin
          check_word("out_data", out_data, exp_stream.pop_front());
          check_flag("out_last", out_last, exp_stream.size() == 0);
        end
      end
    end
  end

  always @(posedge readout_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not finish", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    capture_reset = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = 2'd0;
    wb_dat_w      = 32'd0;
    hw_start      = 1'b0;
    hw_stop       = 1'b0;
    sample_valid  = '0;
    sample_data   = '0;
    depth_ready   = 1'b0;
    out_ready     = 1'b0;
    rng           = 32'hbf0e_7e8c;
    window        = 1'b0;
    mode          = 1'b0;
    data_errors   = 0;
    other_errors  = 0;
    depth_reports = 0;
    cycles        = 0;
    repeat (8) @(posedge readout_clk);
    #10;
    capture_reset = 1'b0;
    run_tests();
    $display("errors: %0d value, %0d other", data_errors, other_errors);
    if (data_errors == 0 && other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+test
hw/sample_buffer_pkg.sv
hw/buffer_regs.sv
hw/capture_control.sv
hw/sample_banks.sv
hw/bank_readout.sv
hw/sample_buffer.sv
test/sample_buffer_chk.sv
test/sample_buffer_tb.sv
